// ==== logic/ratio_pkg.sv ====
`default_nettype none

package ratio_pkg;

    // operand and result width
    localparam int OPERAND_WIDTH = 16;

    // fraction bits applied to the numerator before division
    localparam int FRAC_MAX = 8;
    localparam int FRAC_WIDTH = 4;

    // the numerator after the left shift
    localparam int DIVIDEND_WIDTH = OPERAND_WIDTH + FRAC_MAX;

    // one quotient bit per dividend bit
    localparam int QUOTIENT_WIDTH = DIVIDEND_WIDTH;

    // input register stage plus one stage per quotient bit
    localparam int DIV_STAGES = QUOTIENT_WIDTH + 1;

    // prescale stage, division stages, clamp stage
    localparam int RATIO_LATENCY = DIV_STAGES + 2;

    // register map
    localparam logic REG_ADDR_FRAC = 1'b0;
    localparam logic REG_ADDR_ZERO = 1'b1;

endpackage

`default_nettype wire

// ==== logic/ratio_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module ratio_regs
    import ratio_pkg::*;
(
    input  wire logic                     clk_i,
    input  wire logic                     reset_ni,

    // register write strobe
    input  wire logic                     reg_we_i,
    input  wire logic                     reg_addr_i,
    input  wire logic [OPERAND_WIDTH-1:0] reg_wdata_i,

    // configuration towards the datapath
    output logic      [FRAC_WIDTH-1:0]    frac_bits_o,
    output logic      [OPERAND_WIDTH-1:0] zero_value_o
);

    logic [FRAC_WIDTH-1:0] frac_wdata;
    logic [FRAC_WIDTH-1:0] frac_limited;

    // only the low bits of the write data carry the fraction count
    assign frac_wdata = reg_wdata_i[FRAC_WIDTH-1:0];

    // counts above the dividend headroom fall back to the maximum
    assign frac_limited = (frac_wdata > FRAC_WIDTH'(FRAC_MAX)) ? FRAC_WIDTH'(FRAC_MAX)
                                                               : frac_wdata;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            frac_bits_o  <= '0;
            zero_value_o <= '0;
        end else if (reg_we_i) begin
            case (reg_addr_i)
                REG_ADDR_FRAC: frac_bits_o  <= frac_limited;
                REG_ADDR_ZERO: zero_value_o <= reg_wdata_i;
                default: begin
                    frac_bits_o  <= frac_bits_o;
                    zero_value_o <= zero_value_o;
                end
            endcase
        end
    end

    // a write with an unknown address would silently hit neither register
    a_addr_known: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        reg_we_i |-> !$isunknown(reg_addr_i)
    );

endmodule

`default_nettype wire

// ==== logic/ratio_prescale.sv ====
`timescale 1ns/10ps
`default_nettype none

module ratio_prescale
    import ratio_pkg::*;
(
    input  wire logic                      clk_i,
    input  wire logic                      reset_ni,

    // operand strobe from the producer
    input  wire logic                      valid_i,
    input  wire logic [OPERAND_WIDTH-1:0]  numerator_i,
    input  wire logic [OPERAND_WIDTH-1:0]  denominator_i,
    input  wire logic [FRAC_WIDTH-1:0]     frac_bits_i,

    // towards the division pipeline
    output logic                           valid_o,
    output logic      [DIVIDEND_WIDTH-1:0] dividend_o,
    output logic      [OPERAND_WIDTH-1:0]  divisor_o,
    output logic                           div_zero_o
);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_o    <= 1'b0;
            div_zero_o <= 1'b0;
        end else begin
            valid_o    <= valid_i;
            // the only zero test in the unit, later stages just carry the flag
            div_zero_o <= valid_i && (denominator_i == '0);
        end
    end

    // operand payload, fraction bits widen the numerator to the dividend
    always_ff @(posedge clk_i) begin
        dividend_o <= DIVIDEND_WIDTH'(numerator_i) << frac_bits_i;
        divisor_o  <= denominator_i;
    end

    // a larger shift would push numerator bits out of the dividend
    a_frac_range: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        valid_i |-> frac_bits_i <= FRAC_WIDTH'(FRAC_MAX)
    );

endmodule

`default_nettype wire

// ==== logic/ratio_div_pipe.sv ====
`timescale 1ns/10ps
`default_nettype none

module ratio_div_pipe
    import ratio_pkg::*;
(
    input  wire logic                      clk_i,
    input  wire logic                      reset_ni,

    // from the prescale stage
    input  wire logic                      valid_i,
    input  wire logic [DIVIDEND_WIDTH-1:0] dividend_i,
    input  wire logic [OPERAND_WIDTH-1:0]  divisor_i,
    input  wire logic                      div_zero_i,
    input  wire logic [OPERAND_WIDTH-1:0]  zero_value_i,

    // result strobe
    output logic                           valid_o,
    output logic      [OPERAND_WIDTH-1:0]  result_o,
    output logic                           overflow_o,
    output logic                           div_zero_o
);

    // divisor shifted up to the top quotient bit needs the sum of both widths
    localparam int TRIAL_WIDTH = QUOTIENT_WIDTH + OPERAND_WIDTH;
    localparam int LAST = DIV_STAGES - 1;

    // flag lanes run beside the payload
    logic [DIV_STAGES-1:0]     valid_q;
    logic [DIV_STAGES-1:0]     zero_q;

    // stage payload, index 0 is the input register
    logic [DIVIDEND_WIDTH-1:0] rem_q     [DIV_STAGES];
    logic [QUOTIENT_WIDTH-1:0] quot_q    [DIV_STAGES];
    logic [OPERAND_WIDTH-1:0]  divisor_q [DIV_STAGES];

    // per stage trial subtraction
    logic [TRIAL_WIDTH-1:0]    trial [1:LAST];
    logic [LAST:1]             fits;

    logic                      saturate;

    // stage s decides quotient bit QUOTIENT_WIDTH - s
    always_comb begin
        for (int s = 1; s < DIV_STAGES; s++) begin
            trial[s] = TRIAL_WIDTH'(divisor_q[s-1]) << (QUOTIENT_WIDTH - s);
            fits[s]  = TRIAL_WIDTH'(rem_q[s-1]) >= trial[s];
        end
    end

    always_ff @(posedge clk_i) begin
        rem_q[0]     <= dividend_i;
        quot_q[0]    <= '0;
        divisor_q[0] <= divisor_i;
        for (int s = 1; s < DIV_STAGES; s++) begin
            if (fits[s]) begin
                // a fitting trial is below the remainder, so its upper bits are zero
                rem_q[s]  <= rem_q[s-1] - trial[s][DIVIDEND_WIDTH-1:0];
                quot_q[s] <= quot_q[s-1] | (QUOTIENT_WIDTH'(1) << (QUOTIENT_WIDTH - s));
            end else begin
                rem_q[s]  <= rem_q[s-1];
                quot_q[s] <= quot_q[s-1];
            end
            divisor_q[s] <= divisor_q[s-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_q <= '0;
            zero_q  <= '0;
        end else begin
            valid_q <= {valid_q[DIV_STAGES-2:0], valid_i};
            zero_q  <= {zero_q[DIV_STAGES-2:0], div_zero_i};
        end
    end

    // anything above the result width means the ratio does not fit
    assign saturate = |quot_q[LAST][QUOTIENT_WIDTH-1:OPERAND_WIDTH];

    // clamp stage
    always_ff @(posedge clk_i) begin
        if (zero_q[LAST]) begin
            result_o <= zero_value_i;
        end else if (saturate) begin
            result_o <= '1;
        end else begin
            result_o <= quot_q[LAST][OPERAND_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_o    <= 1'b0;
            overflow_o <= 1'b0;
            div_zero_o <= 1'b0;
        end else begin
            valid_o    <= valid_q[LAST];
            // a zero divisor makes every trial fit, so div-zero masks overflow
            overflow_o <= valid_q[LAST] && !zero_q[LAST] && saturate;
            div_zero_o <= valid_q[LAST] && zero_q[LAST];
        end
    end

    a_flags_exclusive: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        !(overflow_o && div_zero_o)
    );

    a_flags_need_valid: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        (overflow_o || div_zero_o) |-> valid_o
    );

endmodule

`default_nettype wire

// ==== logic/ratio_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module ratio_unit
    import ratio_pkg::*;
(
    input  wire logic                     clk_i,
    input  wire logic                     reset_ni,

    input  wire logic                     valid_i,
    input  wire logic [OPERAND_WIDTH-1:0] numerator_i,
    input  wire logic [OPERAND_WIDTH-1:0] denominator_i,

    input  wire logic                     reg_we_i,
    input  wire logic                     reg_addr_i,
    input  wire logic [OPERAND_WIDTH-1:0] reg_wdata_i,

    output logic                          valid_o,
    output logic      [OPERAND_WIDTH-1:0] result_o,
    output logic                          overflow_o,
    output logic                          div_zero_o
);

    logic [FRAC_WIDTH-1:0]     frac_bits;
    logic [OPERAND_WIDTH-1:0]  zero_value;

    // prescale to pipeline
    logic                      pre_valid;
    logic [DIVIDEND_WIDTH-1:0] pre_dividend;
    logic [OPERAND_WIDTH-1:0]  pre_divisor;
    logic                      pre_div_zero;

    ratio_regs i_ratio_regs (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .reg_we_i     (reg_we_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .frac_bits_o  (frac_bits),
        .zero_value_o (zero_value)
    );

    ratio_prescale i_ratio_prescale (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .valid_i       (valid_i),
        .numerator_i   (numerator_i),
        .denominator_i (denominator_i),
        .frac_bits_i   (frac_bits),
        .valid_o       (pre_valid),
        .dividend_o    (pre_dividend),
        .divisor_o     (pre_divisor),
        .div_zero_o    (pre_div_zero)
    );

    ratio_div_pipe i_ratio_div_pipe (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .valid_i      (pre_valid),
        .dividend_i   (pre_dividend),
        .divisor_i    (pre_divisor),
        .div_zero_i   (pre_div_zero),
        .zero_value_i (zero_value),
        .valid_o      (valid_o),
        .result_o     (result_o),
        .overflow_o   (overflow_o),
        .div_zero_o   (div_zero_o)
    );

endmodule

`default_nettype wire

// ==== tb/ratio_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module ratio_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_no = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb/ratio_unit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module ratio_unit_tb
    import ratio_pkg::*;
;

    localparam int CLK_PERIOD_NS = 100;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_GAP = 3;
    localparam int TOTAL_OPS = 40 + 64 + 60 + 13 + 8;
    localparam int NUM_DRAINS = 8;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_OPS * (MAX_GAP + 1)
                                     + NUM_DRAINS * (RATIO_LATENCY + 4) + 100;
    localparam longint RESULT_MAX = (64'd1 << OPERAND_WIDTH) - 64'd1;

    logic                     clk_i;
    logic                     reset_ni;
    logic                     valid_i;
    logic [OPERAND_WIDTH-1:0] numerator_i;
    logic [OPERAND_WIDTH-1:0] denominator_i;
    logic                     reg_we_i;
    logic                     reg_addr_i;
    logic [OPERAND_WIDTH-1:0] reg_wdata_i;
    logic                     valid_o;
    logic [OPERAND_WIDTH-1:0] result_o;
    logic                     overflow_o;
    logic                     div_zero_o;

    // expected results in issue order, each with the edge that should see it
    int                       due_q[$];
    logic [OPERAND_WIDTH-1:0] result_q[$];
    logic [1:0]               flags_q[$];

    int          cycle = 0;
    int          cfg_frac = 0;
    logic [15:0] cfg_zero = '0;
    logic [31:0] lcg_state;
    int          checked = 0;
    int          value_errors = 0;
    int          timing_errors = 0;

    ratio_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_clock_gen (
        .clk_o    (clk_i),
        .reset_no (reset_ni)
    );

    ratio_unit i_ratio_unit (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .valid_i       (valid_i),
        .numerator_i   (numerator_i),
        .denominator_i (denominator_i),
        .reg_we_i      (reg_we_i),
        .reg_addr_i    (reg_addr_i),
        .reg_wdata_i   (reg_wdata_i),
        .valid_o       (valid_o),
        .result_o      (result_o),
        .overflow_o    (overflow_o),
        .div_zero_o    (div_zero_o)
    );

    always @(posedge clk_i) cycle <= cycle + 1;

    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper half, the low bits of an LCG repeat quickly
    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = rand_next();
        return r[31:16];
    endfunction

    // {overflow, div_zero, result}
    function automatic logic [OPERAND_WIDTH+1:0] ref_ratio(input logic [15:0] num,
                                                           input logic [15:0] den,
                                                           input int frac,
                                                           input logic [15:0] zero_val);
        longint quot;
        if (den == '0) begin
            return {1'b0, 1'b1, zero_val};
        end
        quot = (longint'(num) << frac) / longint'(den);
        if (quot > RESULT_MAX) begin
            return {1'b1, 1'b0, 16'hffff};
        end
        return {1'b0, 1'b0, quot[OPERAND_WIDTH-1:0]};
    endfunction

    task automatic check_result(input logic [OPERAND_WIDTH-1:0] got,
                                input logic [OPERAND_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: result %h, expected %h", $time, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_flags(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: overflow/div_zero %b, expected %b",
                     $time, got, exp);
            value_errors++;
        end
    endtask

    task automatic send_op(input logic [15:0] num, input logic [15:0] den);
        logic [OPERAND_WIDTH+1:0] exp_word;
        exp_word = ref_ratio(num, den, cfg_frac, cfg_zero);
        valid_i       = 1'b1;
        numerator_i   = num;
        denominator_i = den;
        // sampled on the next rising edge
        due_q.push_back(cycle + 1 + RATIO_LATENCY);
        result_q.push_back(exp_word[OPERAND_WIDTH-1:0]);
        flags_q.push_back(exp_word[OPERAND_WIDTH+1:OPERAND_WIDTH]);
        @(negedge clk_i);
        valid_i = 1'b0;
    endtask

    task automatic write_reg(input logic addr, input logic [15:0] data);
        reg_we_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        if (addr == REG_ADDR_FRAC) begin
            cfg_frac = int'(data[FRAC_WIDTH-1:0]);
            if (cfg_frac > FRAC_MAX) cfg_frac = FRAC_MAX;
        end else begin
            cfg_zero = data;
        end
        @(negedge clk_i);
        reg_we_i = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    // no operation in flight before configuration changes
    task automatic wait_idle();
        while (due_q.size() != 0) @(negedge clk_i);
        @(negedge clk_i);
    endtask

    task automatic send_random(input int count, input bit gaps);
        int          shift;
        logic [15:0] num;
        logic [15:0] den;
        for (int i = 0; i < count; i++) begin
            num   = rand16();
            shift = int'(rand16() >> 12);
            den   = rand16() >> shift;
            send_op(num, den);
            if (gaps) idle(int'(rand16() >> 14));
        end
    endtask

    // outputs are stable at the falling edge, the next rising edge is the one that sees them
    always @(negedge clk_i) begin : compare_proc
        int seen_cycle;
        seen_cycle = cycle + 1;
        if (reset_ni === 1'b1) begin
            if ($isunknown(valid_o)) begin
                $display("valid_o is unknown at time %0t", $time);
                timing_errors++;
            end else if (valid_o) begin
                if (due_q.size() == 0) begin
                    $display("valid_o high at time %0t with no operation outstanding", $time);
                    timing_errors++;
                end else begin
                    if (due_q[0] != seen_cycle) begin
                        $display("Result arrived at cycle %0d but was due at cycle %0d",
                                 seen_cycle, due_q[0]);
                        timing_errors++;
                    end
                    check_result(result_o, result_q[0]);
                    check_flags({overflow_o, div_zero_o}, flags_q[0]);
                    void'(due_q.pop_front());
                    void'(result_q.pop_front());
                    void'(flags_q.pop_front());
                    checked++;
                end
            end else if (due_q.size() != 0 && due_q[0] <= seen_cycle) begin
                $display("A result due at cycle %0d never arrived", due_q[0]);
                timing_errors++;
                void'(due_q.pop_front());
                void'(result_q.pop_front());
                void'(flags_q.pop_front());
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("Timeout: the run did not end within %0d clock cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : stimulus
        valid_i       = 1'b0;
        numerator_i   = '0;
        denominator_i = '0;
        reg_we_i      = 1'b0;
        reg_addr_i    = 1'b0;
        reg_wdata_i   = '0;
        lcg_state     = 32'd16877;
        wait (reset_ni === 1'b1);
        @(negedge clk_i);

        // integer division after reset, idle first
        idle(10);
        send_random(40, 1'b1);
        wait_idle();

        // one strobe every cycle
        send_random(64, 1'b0);
        wait_idle();

        // fraction bits, 15 is limited to 8
        write_reg(REG_ADDR_FRAC, 16'd4);
        send_random(30, 1'b1);
        wait_idle();
        write_reg(REG_ADDR_FRAC, 16'd15);
        send_random(27, 1'b1);
        send_op(16'd3, 16'd2);
        send_op(16'd1000, 16'd7);
        send_op(16'hffff, 16'hffff);
        wait_idle();

        // clamping with frac 8
        send_op(16'hffff, 16'd1);
        send_op(16'hffff, 16'd256);
        send_op(16'd256, 16'd1);
        for (int i = 0; i < 10; i++) begin
            send_op(rand16(), rand16() & 16'h00ff);
        end
        wait_idle();

        // zero denominator
        write_reg(REG_ADDR_ZERO, 16'hbeef);
        send_op(16'd0, 16'd0);
        send_op(16'd1234, 16'd0);
        for (int i = 0; i < 6; i++) begin
            send_op(rand16(), rand16() & 16'h0001);
        end
        wait_idle();
        idle(10);

        $display("Checked %0d results: %0d value errors, %0d timing errors",
                 checked, value_errors, timing_errors);
        if (value_errors + timing_errors == 0 && checked == TOTAL_OPS) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ratio_unit.f ====
logic/ratio_pkg.sv
logic/ratio_regs.sv
logic/ratio_prescale.sv
logic/ratio_div_pipe.sv
logic/ratio_unit.sv
tb/ratio_clock_gen.sv
tb/ratio_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the ratio unit testbench with Verilator.

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=ratio_unit_sim

verilator --binary --assert \
    -f ratio_unit.f \
    --top-module ratio_unit_tb \
    -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi

if ! grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0
